/* build.f */
+incdir+source
source/pmp_pkg.sv
source/pmp_csr_ctrl.sv
source/pmp_region_decode.sv
source/pmp_access_check.sv
source/pmp_fault_log.sv
source/pmp_unit.sv
tb/pmp_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the PMP unit testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module pmp_unit_tb \
  -f build.f \
  -o pmp_unit_sim

./obj_dir/pmp_unit_sim | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* tb/pmp_unit_tb.sv */
/*
 * Table-driven testbench for the PMP unit: CSR table, access table
 * checked against a behavioral reference, fault log sequence, watchdog
 */
`timescale 1ns/1ns
`include "pmp_config.svh"

module pmp_unit_tb import pmp_pkg::*; ();

  localparam int NumRegions = `PMP_NUM_REGIONS;
  localparam int NumChan    = `PMP_NUM_CHAN;
  localparam int ChanW      = `PMP_CHAN_IDX_W;
  localparam int Lsb        = `PMP_GRANULARITY + 2;
  localparam int ClkPeriod  = 8;

  typedef struct packed {
    logic [11:0] num;
    logic [31:0] data;
    logic [31:0] exp;
  } csr_row_t;

  typedef struct packed {
    logic        chan;
    logic [33:0] addr;
    logic [3:0]  rnd;    // Count of low address bits drawn from the LFSR
    pmp_req_e    typ;
    priv_lvl_e   priv;
  } acc_row_t;

  typedef struct packed {
    logic        clr;
    logic [1:0]  vld;
    logic [33:0] addr0;
    pmp_req_e    typ0;
    logic [33:0] addr1;
    pmp_req_e    typ1;
  } log_row_t;

  logic                          clk;
  logic                          rst_n;
  logic                          csr_we;
  logic [11:0]                   csr_num;
  logic [31:0]                   csr_wdata;
  logic [31:0]                   csr_rdata;
  logic [NumChan-1:0]            req_valid;
  logic [NumChan-1:0][33:0]      req_addr;
  pmp_req_e [NumChan-1:0]        req_type;
  priv_lvl_e [NumChan-1:0]       priv_lvl;
  logic [NumChan-1:0]            req_err;
  logic                          fault_clr;
  logic                          fault_valid;
  logic [33:0]                   fault_addr;
  logic [ChanW-1:0]              fault_chan;
  pmp_req_e                      fault_type;

  int          err_cnt;
  int          chk_cnt;
  logic [31:0] lfsr_q;
  csr_row_t    csr_q[$];
  acc_row_t    acc_q[$];
  log_row_t    log_q[$];

  // Reference register state and fault log state
  logic [7:0]  ref_cfg [NumRegions];
  logic [31:0] ref_addr [NumRegions];
  logic        log_valid;
  logic [33:0] log_addr;
  logic [ChanW-1:0] log_chan;
  pmp_req_e    log_type;

  pmp_unit dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .csr_we_i      (csr_we),
    .csr_num_i     (csr_num),
    .csr_wdata_i   (csr_wdata),
    .csr_rdata_o   (csr_rdata),
    .req_valid_i   (req_valid),
    .req_addr_i    (req_addr),
    .req_type_i    (req_type),
    .priv_lvl_i    (priv_lvl),
    .req_err_o     (req_err),
    .fault_clr_i   (fault_clr),
    .fault_valid_o (fault_valid),
    .fault_addr_o  (fault_addr),
    .fault_chan_o  (fault_chan),
    .fault_type_o  (fault_type)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[i]   = lfsr_q[0];
    end
    return v;
  endfunction

  function automatic pmp_req_e next_type(input pmp_req_e t);
    case (t)
      PMP_ACC_EXEC:  return PMP_ACC_WRITE;
      PMP_ACC_WRITE: return PMP_ACC_READ;
      default:       return PMP_ACC_EXEC;
    endcase
  endfunction

  function automatic logic ref_err(input logic [33:0] a, input pmp_req_e typ,
                                   input priv_lvl_e priv);
    logic [33:0] full;
    logic [33:0] start;
    logic [33:0] mask;
    logic [1:0]  mode;
    logic        hit;
    logic        perm;
    logic        m_fault;
    logic        u_allow;
    int          ones;
    m_fault = 1'b0;
    u_allow = 1'b0;
    for (int r = 0; r < NumRegions; r++) begin
      mode = ref_cfg[r][4:3];
      full = {ref_addr[r], 2'b00};
      if (mode == PMP_MODE_TOR && r > 0) begin
        start = {ref_addr[r-1], 2'b00};
      end else if (mode == PMP_MODE_TOR) begin
        start = '0;
      end else begin
        start = full;
      end
      // NAPOT size comes from the run of ones just above the granule
      mask = '1;
      if (mode == PMP_MODE_NAPOT) begin
        ones = 0;
        while (Lsb + ones < 34 && full[Lsb+ones]) ones++;
        for (int b = Lsb; b <= Lsb + ones && b < 34; b++) mask[b] = 1'b0;
      end
      hit = (mode != PMP_MODE_OFF) && ((a >> Lsb) >= ((start & mask) >> Lsb)) &&
            ((a >> Lsb) <= (full >> Lsb));
      case (typ)
        PMP_ACC_EXEC:  perm = ref_cfg[r][2];
        PMP_ACC_WRITE: perm = ref_cfg[r][1];
        default:       perm = ref_cfg[r][0];
      endcase
      if (hit && ref_cfg[r][7] && !perm) m_fault = 1'b1;
      if (hit && perm) u_allow = 1'b1;
    end
    return (priv == PRIV_LVL_M) ? m_fault : !u_allow;
  endfunction

  function automatic void model_csr_write(input logic [11:0] num, input logic [31:0] data);
    logic [7:0] b;
    logic       tor_lock;
    for (int k = 0; k < NumRegions / 4; k++) begin
      if (num == `PMP_CSR_CFG_BASE + k) begin
        for (int s = 0; s < 4; s++) begin
          b = data[8*s +: 8];
          if (!ref_cfg[4*k+s][7] && !(b[1] && !b[0])) ref_cfg[4*k+s] = b & 8'h9F;
        end
      end
    end
    for (int i = 0; i < NumRegions; i++) begin
      if (num == `PMP_CSR_ADDR_BASE + i) begin
        tor_lock = (i + 1 < NumRegions) && ref_cfg[i+1][7] &&
                   (ref_cfg[i+1][4:3] == PMP_MODE_TOR);
        if (!ref_cfg[i][7] && !tor_lock) ref_addr[i] = data;
      end
    end
  endfunction

  // ------------------------------------------------------------
  // Tables
  // ------------------------------------------------------------

  task automatic fill_tables();
    // Region 0 as NAPOT XR, 1 as OFF, 2 as TOR RW and 3 as TOR X, then 3 gets locked
    csr_q.push_back({12'h3B0, 32'h0000_0403, 32'h0000_0403});
    csr_q.push_back({12'h3B1, 32'h0000_0800, 32'h0000_0800});
    csr_q.push_back({12'h3B2, 32'h0000_0C00, 32'h0000_0C00});
    csr_q.push_back({12'h3B3, 32'h0000_1000, 32'h0000_1000});
    csr_q.push_back({12'h3A0, 32'h0C0B_077D, 32'h0C0B_071D});
    csr_q.push_back({12'h3A0, 32'h0E0A_071D, 32'h0C0B_071D});
    csr_q.push_back({12'h3A0, 32'h0C0B_051D, 32'h0C0B_051D});
    csr_q.push_back({12'h3A1, 32'hFFFF_FFFF, 32'h0000_0000});
    csr_q.push_back({12'h3B4, 32'h1234_5678, 32'h0000_0000});
    csr_q.push_back({12'h39F, 32'hFFFF_FFFF, 32'h0000_0000});
    csr_q.push_back({12'h3A0, 32'h8C0B_051D, 32'h8C0B_051D});
    csr_q.push_back({12'h3A0, 32'h0F0F_071D, 32'h8C0F_071D});
    csr_q.push_back({12'h3B3, 32'h0000_2000, 32'h0000_1000});
    csr_q.push_back({12'h3B2, 32'h0000_0D00, 32'h0000_0C00});
    csr_q.push_back({12'h3B1, 32'h0000_0900, 32'h0000_0900});
    csr_q.push_back({12'h3A0, 32'h0C0B_051D, 32'h8C0B_051D});

    acc_q.push_back({1'b0, 34'h0_0000_1000, 4'd0, PMP_ACC_EXEC, PRIV_LVL_U});
    acc_q.push_back({1'b0, 34'h0_0000_100F, 4'd0, PMP_ACC_EXEC, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_0FFF, 4'd0, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_1010, 4'd0, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b0, 34'h0_0000_1000, 4'd4, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_1000, 4'd4, PMP_ACC_WRITE, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_2400, 4'd0, PMP_ACC_WRITE, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_3003, 4'd0, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b0, 34'h0_0000_23FF, 4'd0, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b0, 34'h0_0000_3004, 4'd0, PMP_ACC_WRITE, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_2400, 4'd9, PMP_ACC_WRITE, PRIV_LVL_U});
    // Region 1 grants X but is OFF
    acc_q.push_back({1'b0, 34'h0_0000_2400, 4'd0, PMP_ACC_EXEC, PRIV_LVL_U});
    acc_q.push_back({1'b0, 34'h0_0000_3000, 4'd0, PMP_ACC_EXEC, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_2FFF, 4'd0, PMP_ACC_EXEC, PRIV_LVL_U});
    acc_q.push_back({1'b0, 34'h0_0000_4003, 4'd0, PMP_ACC_EXEC, PRIV_LVL_U});
    acc_q.push_back({1'b0, 34'h0_0000_4004, 4'd0, PMP_ACC_EXEC, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_3800, 4'd10, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_3000, 4'd0, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h3_0000_1000, 4'd0, PMP_ACC_READ, PRIV_LVL_U});
    acc_q.push_back({1'b1, 34'h0_0000_2400, 4'd0, PMP_ACC_EXEC, PRIV_LVL_M});
    acc_q.push_back({1'b1, 34'h0_0000_8000, 4'd0, PMP_ACC_WRITE, PRIV_LVL_M});
    acc_q.push_back({1'b0, 34'h0_0000_3800, 4'd0, PMP_ACC_READ, PRIV_LVL_M});
    acc_q.push_back({1'b1, 34'h0_0000_3800, 4'd8, PMP_ACC_WRITE, PRIV_LVL_M});
    acc_q.push_back({1'b0, 34'h0_0000_3800, 4'd0, PMP_ACC_EXEC, PRIV_LVL_M});
    acc_q.push_back({1'b0, 34'h0_0000_1004, 4'd0, PMP_ACC_WRITE, PRIV_LVL_M});

    log_q.push_back({3'b100, 34'h8000, PMP_ACC_EXEC, 34'h8000, PMP_ACC_EXEC});
    log_q.push_back({3'b000, 34'h8000, PMP_ACC_READ, 34'h8004, PMP_ACC_WRITE});
    log_q.push_back({3'b011, 34'h8010, PMP_ACC_READ, 34'h8020, PMP_ACC_WRITE});
    log_q.push_back({3'b010, 34'h1000, PMP_ACC_EXEC, 34'h8030, PMP_ACC_WRITE});
    log_q.push_back({3'b100, 34'h1000, PMP_ACC_EXEC, 34'h1000, PMP_ACC_EXEC});
    log_q.push_back({3'b111, 34'h8040, PMP_ACC_READ, 34'h8044, PMP_ACC_READ});
    log_q.push_back({3'b011, 34'h1000, PMP_ACC_EXEC, 34'h8048, PMP_ACC_EXEC});
    log_q.push_back({3'b001, 34'h8050, PMP_ACC_WRITE, 34'h1000, PMP_ACC_EXEC});
    log_q.push_back({3'b100, 34'h1000, PMP_ACC_EXEC, 34'h1000, PMP_ACC_EXEC});
    log_q.push_back({3'b010, 34'h1000, PMP_ACC_EXEC, 34'h3800, PMP_ACC_READ});
    log_q.push_back({3'b100, 34'h1000, PMP_ACC_EXEC, 34'h1000, PMP_ACC_EXEC});
  endtask

  // ------------------------------------------------------------
  // Table runners start and end 1 ns after a rising edge
  // ------------------------------------------------------------

  task automatic run_csr_table();
    logic [31:0] rdata;
    for (int i = 0; i < csr_q.size(); i++) begin
      csr_we    = 1'b1;
      csr_num   = csr_q[i].num;
      csr_wdata = csr_q[i].data;
      @(posedge clk);
      #1;
      csr_we = 1'b0;
      model_csr_write(csr_q[i].num, csr_q[i].data);
      #1;
      rdata = csr_rdata;
      chk_cnt++;
      assert (rdata === csr_q[i].exp) else begin
        err_cnt++;
        $display("MISMATCH at %0t: CSR %h reads %h, expected %h",
                 $time, csr_q[i].num, rdata, csr_q[i].exp);
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_access_table();
    int       c;
    int       o;
    logic     exp;
    pmp_req_e ot;
    for (int i = 0; i < acc_q.size(); i++) begin
      c  = acc_q[i].chan;
      o  = (c + 1) % NumChan;
      // The other channel sees the same address with a different type
      ot = next_type(acc_q[i].typ);
      if (random_bits(1) != 0) ot = next_type(ot);
      req_addr[c] = acc_q[i].addr | 34'(random_bits(int'(acc_q[i].rnd)));
      req_type[c] = acc_q[i].typ;
      priv_lvl[c] = acc_q[i].priv;
      req_addr[o] = req_addr[c];
      req_type[o] = ot;
      priv_lvl[o] = acc_q[i].priv;
      #2;
      for (int k = 0; k < NumChan; k++) begin
        exp = ref_err(req_addr[k], req_type[k], priv_lvl[k]);
        chk_cnt++;
        assert (req_err[k] === exp) else begin
          err_cnt++;
          $display("MISMATCH at %0t: row %0d chan %0d addr %h type %0d err %b, expected %b",
                   $time, i, k, req_addr[k], req_type[k], req_err[k], exp);
        end
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_log_table();
    logic [NumChan-1:0] hit;
    for (int i = 0; i < log_q.size(); i++) begin
      fault_clr   = log_q[i].clr;
      req_valid   = log_q[i].vld;
      req_addr[0] = log_q[i].addr0;
      req_type[0] = log_q[i].typ0;
      req_addr[1] = log_q[i].addr1;
      req_type[1] = log_q[i].typ1;
      for (int k = 0; k < NumChan; k++) priv_lvl[k] = PRIV_LVL_U;
      #2;
      for (int k = 0; k < NumChan; k++) begin
        hit[k] = req_valid[k] && ref_err(req_addr[k], req_type[k], priv_lvl[k]);
      end
      if (fault_clr) begin
        log_valid = 1'b0;
      end else if (!log_valid && hit != 0) begin
        for (int k = 0; k < NumChan; k++) begin
          if (hit[k] && !log_valid) begin
            log_valid = 1'b1;
            log_addr  = req_addr[k];
            log_chan  = ChanW'(k);
            log_type  = req_type[k];
          end
        end
      end
      @(posedge clk);
      #1;
      chk_cnt++;
      assert (fault_valid === log_valid &&
              (!log_valid || (fault_addr === log_addr && fault_chan === log_chan &&
                              fault_type === log_type))) else begin
        err_cnt++;
        $display("MISMATCH at %0t: log row %0d got %b %h %0d %0d, expected %b %h %0d %0d",
                 $time, i, fault_valid, fault_addr, fault_chan, fault_type,
                 log_valid, log_addr, log_chan, log_type);
      end
    end
    req_valid = '0;
    fault_clr = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------

  initial begin
    rst_n     = 1'b0;
    csr_we    = 1'b0;
    csr_num   = '0;
    csr_wdata = '0;
    req_valid = '0;
    req_addr  = '0;
    fault_clr = 1'b0;
    for (int k = 0; k < NumChan; k++) begin
      req_type[k] = PMP_ACC_EXEC;
      priv_lvl[k] = PRIV_LVL_U;
    end
    for (int r = 0; r < NumRegions; r++) begin
      ref_cfg[r]  = '0;
      ref_addr[r] = '0;
    end
    log_valid = 1'b0;
    err_cnt   = 0;
    chk_cnt   = 0;
    lfsr_q    = 32'h8384;
    fill_tables();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;
    run_csr_table();
    run_access_table();
    run_log_table();
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = (csr_q.size() + acc_q.size() + log_q.size()) * 20;
    #(limit * ClkPeriod);
    $display("ERROR: watchdog expired after %0d cycles, the tables did not complete", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* source/pmp_unit.sv */
/*
 * PMP unit top: CSR control, region decode, access check and fault log
 */
`timescale 1ns/1ns
`include "pmp_config.svh"

module pmp_unit import pmp_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  // CSR port
  input  logic                                csr_we_i,
  input  logic [11:0]                         csr_num_i,
  input  logic [31:0]                         csr_wdata_i,
  output logic [31:0]                         csr_rdata_o,

  // Access channels
  input  logic [`PMP_NUM_CHAN-1:0]            req_valid_i,
  input  logic [`PMP_NUM_CHAN-1:0][33:0]      req_addr_i,
  input  pmp_req_e [`PMP_NUM_CHAN-1:0]        req_type_i,
  input  priv_lvl_e [`PMP_NUM_CHAN-1:0]       priv_lvl_i,
  output logic [`PMP_NUM_CHAN-1:0]            req_err_o,

  // Fault log
  input  logic                                fault_clr_i,
  output logic                                fault_valid_o,
  output logic [33:0]                         fault_addr_o,
  output logic [`PMP_CHAN_IDX_W-1:0]          fault_chan_o,
  output pmp_req_e                            fault_type_o
);

  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]                      cfg;
  logic [`PMP_NUM_REGIONS-1:0][33:0]                    addr;
  logic [`PMP_NUM_REGIONS-1:0][33:0]                    region_start;
  logic [`PMP_NUM_REGIONS-1:0][33:`PMP_GRANULARITY+2]   region_mask;

  pmp_csr_ctrl csr_ctrl0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .csr_we_i     (csr_we_i),
    .csr_num_i    (csr_num_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .cfg_o        (cfg),
    .addr_o       (addr)
  );

  pmp_region_decode region_decode0 (
    .cfg_i          (cfg),
    .addr_i         (addr),
    .region_start_o (region_start),
    .region_mask_o  (region_mask)
  );

  pmp_access_check access_check0 (
    .cfg_i          (cfg),
    .addr_i         (addr),
    .region_start_i (region_start),
    .region_mask_i  (region_mask),
    .req_addr_i     (req_addr_i),
    .req_type_i     (req_type_i),
    .priv_lvl_i     (priv_lvl_i),
    .chan_err_o     (req_err_o)
  );

  pmp_fault_log fault_log0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_type_i    (req_type_i),
    .chan_err_i    (req_err_o),
    .fault_clr_i   (fault_clr_i),
    .fault_valid_o (fault_valid_o),
    .fault_addr_o  (fault_addr_o),
    .fault_chan_o  (fault_chan_o),
    .fault_type_o  (fault_type_o)
  );

endmodule

/* source/pmp_fault_log.sv */
/*
 * Sticky log of the first faulting valid access
 */
`timescale 1ns/1ns
`include "pmp_config.svh"

module pmp_fault_log import pmp_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  logic [`PMP_NUM_CHAN-1:0]            req_valid_i,
  input  logic [`PMP_NUM_CHAN-1:0][33:0]      req_addr_i,
  input  pmp_req_e [`PMP_NUM_CHAN-1:0]        req_type_i,
  input  logic [`PMP_NUM_CHAN-1:0]            chan_err_i,

  input  logic                                fault_clr_i,
  output logic                                fault_valid_o,
  output logic [33:0]                         fault_addr_o,
  output logic [`PMP_CHAN_IDX_W-1:0]          fault_chan_o,
  output pmp_req_e                            fault_type_o
);

  localparam int unsigned NumChan = `PMP_NUM_CHAN;
  localparam int unsigned ChanW   = `PMP_CHAN_IDX_W;

  logic [NumChan-1:0] hit_vec;
  logic [ChanW-1:0]   sel_chan;
  logic               capture;

  assign hit_vec = req_valid_i & chan_err_i;

  // Scan downward so the lowest faulting channel is left selected
  always_comb begin
    sel_chan = '0;
    for (int c = NumChan - 1; c >= 0; c--) begin
      if (hit_vec[c]) begin
        sel_chan = ChanW'(c);
      end
    end
  end

  // Clear wins over a new fault in the same cycle
  assign capture = |hit_vec & ~fault_valid_o & ~fault_clr_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fault_valid_o <= 1'b0;
    end else if (fault_clr_i) begin
      fault_valid_o <= 1'b0;
    end else if (capture) begin
      fault_valid_o <= 1'b1;
    end
  end

  // Record payload, held until the next clear
  always_ff @(posedge clk_i) begin
    if (capture) begin
      fault_addr_o <= req_addr_i[sel_chan];
      fault_chan_o <= sel_chan;
      fault_type_o <= req_type_i[sel_chan];
    end
  end

endmodule

/* source/pmp_access_check.sv */
/*
 * Access check: range match and permission check of every channel
 * against every region, one error level per channel
 */
`timescale 1ns/1ns
`include "pmp_config.svh"

module pmp_access_check import pmp_pkg::*; (
  // Region configuration
  input  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]                       cfg_i,
  input  logic [`PMP_NUM_REGIONS-1:0][33:0]                     addr_i,
  input  logic [`PMP_NUM_REGIONS-1:0][33:0]                     region_start_i,
  input  logic [`PMP_NUM_REGIONS-1:0][33:`PMP_GRANULARITY+2]    region_mask_i,

  // Requests
  input  logic [`PMP_NUM_CHAN-1:0][33:0]                        req_addr_i,
  input  pmp_req_e [`PMP_NUM_CHAN-1:0]                          req_type_i,
  input  priv_lvl_e [`PMP_NUM_CHAN-1:0]                         priv_lvl_i,
  output logic [`PMP_NUM_CHAN-1:0]                              chan_err_o
);

  localparam int unsigned NumRegions = `PMP_NUM_REGIONS;
  localparam int unsigned NumChan    = `PMP_NUM_CHAN;
  localparam int unsigned Lsb        = `PMP_GRANULARITY + 2;

  logic [NumRegions-1:0] region_on;

  // Permission bit needed by one access type
  function automatic logic perm_granted(pmp_cfg_t cfg, pmp_req_e acc);
    logic ok;
    case (acc)
      PMP_ACC_EXEC:  ok = cfg.exec;
      PMP_ACC_WRITE: ok = cfg.write;
      PMP_ACC_READ:  ok = cfg.read;
      default:       ok = 1'b0;
    endcase
    return ok;
  endfunction

  for (genvar r = 0; r < NumRegions; r++) begin : g_on
    assign region_on[r] = (cfg_i[r].mode != PMP_MODE_OFF);
  end

  // ------------------------------------------------------------
  // Per-channel checks
  // ------------------------------------------------------------

  for (genvar c = 0; c < NumChan; c++) begin : g_chan
    logic [NumRegions-1:0] match_lo;
    logic [NumRegions-1:0] match_hi;
    logic [NumRegions-1:0] match;
    logic [NumRegions-1:0] perm_ok;
    logic [NumRegions-1:0] m_fault;
    logic [NumRegions-1:0] u_allow;

    for (genvar r = 0; r < NumRegions; r++) begin : g_reg
      // Same pair of compares serves TOR, NA4 and NAPOT
      assign match_lo[r] = (req_addr_i[c][33:Lsb] >=
                            (region_start_i[r][33:Lsb] & region_mask_i[r]));
      assign match_hi[r] = (req_addr_i[c][33:Lsb] <= addr_i[r][33:Lsb]);
      assign match[r]    = match_lo[r] & match_hi[r] & region_on[r];

      assign perm_ok[r]  = perm_granted(cfg_i[r], req_type_i[c]);

      // Machine mode only trips on locked regions
      assign m_fault[r]  = match[r] & cfg_i[r].lock & ~perm_ok[r];
      assign u_allow[r]  = match[r] & perm_ok[r];
    end

    // User mode is denied unless some region grants the access
    assign chan_err_o[c] = (priv_lvl_i[c] == PRIV_LVL_M) ? |m_fault : ~|u_allow;
  end

endmodule

/* source/pmp_region_decode.sv */
/*
 * Region decode: TOR start address and NAPOT address mask per region
 */
`timescale 1ns/1ns
`include "pmp_config.svh"

module pmp_region_decode import pmp_pkg::*; (
  input  pmp_cfg_t [`PMP_NUM_REGIONS-1:0]                           cfg_i,
  input  logic [`PMP_NUM_REGIONS-1:0][33:0]                         addr_i,
  output logic [`PMP_NUM_REGIONS-1:0][33:0]                         region_start_o,
  output logic [`PMP_NUM_REGIONS-1:0][33:`PMP_GRANULARITY+2]        region_mask_o
);

  localparam int unsigned NumRegions = `PMP_NUM_REGIONS;
  localparam int unsigned Lsb        = `PMP_GRANULARITY + 2;

  // ------------------------------------------------------------
  // Start address
  // ------------------------------------------------------------

  // TOR takes the previous region's address as its base
  for (genvar r = 0; r < NumRegions; r++) begin : g_start
    if (r == 0) begin : g_first
      assign region_start_o[r] = (cfg_i[r].mode == PMP_MODE_TOR) ? 34'h0 : addr_i[r];
    end else begin : g_rest
      assign region_start_o[r] = (cfg_i[r].mode == PMP_MODE_TOR) ? addr_i[r-1] : addr_i[r];
    end
  end

  // ------------------------------------------------------------
  // NAPOT mask
  // ------------------------------------------------------------

  // The run of trailing ones in pmpaddr sets the size, so a bit is
  // masked while every bit below it (down to the granule) is one
  always_comb begin
    logic napot;
    logic ones_below;
    for (int r = 0; r < NumRegions; r++) begin
      napot      = (cfg_i[r].mode == PMP_MODE_NAPOT);
      ones_below = 1'b1;
      for (int b = Lsb; b < 34; b++) begin
        region_mask_o[r][b] = ~napot | ~ones_below;
        ones_below          = ones_below & addr_i[r][b];
      end
    end
  end

endmodule

/* source/pmp_csr_ctrl.sv */
/*
 * PMP control registers: pmpcfg/pmpaddr storage, CSR read mux,
 * lock rules and WARL filtering of written config bytes
 */
`timescale 1ns/1ns
`include "pmp_config.svh"

module pmp_csr_ctrl import pmp_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  // CSR port
  input  logic                                csr_we_i,
  input  logic [11:0]                         csr_num_i,
  input  logic [31:0]                         csr_wdata_i,
  output logic [31:0]                         csr_rdata_o,

  // Registered configuration for the datapath
  output pmp_cfg_t [`PMP_NUM_REGIONS-1:0]     cfg_o,
  output logic [`PMP_NUM_REGIONS-1:0][33:0]   addr_o
);

  localparam int unsigned NumRegions = `PMP_NUM_REGIONS;
  localparam int unsigned NumWords   = `PMP_NUM_CFG_WORDS;

  logic [11:0]                    cfg_off;
  logic [11:0]                    addr_off;
  logic                           cfg_hit;
  logic                           addr_hit;
  pmp_cfg_word_u                  wr_word;
  pmp_cfg_word_u                  rd_word;
  logic [31:0]                    addr_rdata;
  pmp_cfg_t [NumRegions-1:0]      cfg_q;
  pmp_cfg_t [NumRegions-1:0]      cfg_wval;
  logic [NumRegions-1:0][31:0]    addr_q;
  logic [NumRegions-1:0]          cfg_we;
  logic [NumRegions-1:0]          addr_we;

  // ------------------------------------------------------------
  // CSR number decode
  // ------------------------------------------------------------

  // Offsets wrap below the base, so one compare covers both ends
  assign cfg_off  = csr_num_i - `PMP_CSR_CFG_BASE;
  assign addr_off = csr_num_i - `PMP_CSR_ADDR_BASE;
  assign cfg_hit  = (cfg_off < NumWords);
  assign addr_hit = (addr_off < NumRegions);

  assign wr_word.raw = csr_wdata_i;

  // ------------------------------------------------------------
  // Per-region write enables
  // ------------------------------------------------------------

  for (genvar r = 0; r < NumRegions; r++) begin : g_region
    localparam int unsigned Word = r / 4;
    localparam int unsigned Slot = r % 4;

    pmp_cfg_t new_cfg;
    logic     wr_no_rd;
    logic     tor_locked;

    assign new_cfg  = wr_word.entry[Slot];
    // W without R is a reserved combination
    assign wr_no_rd = new_cfg.write & ~new_cfg.read;

    // Reserved field always lands as zero
    assign cfg_wval[r] = '{lock:     new_cfg.lock,
                           reserved: 2'b00,
                           mode:     new_cfg.mode,
                           exec:     new_cfg.exec,
                           write:    new_cfg.write,
                           read:     new_cfg.read};

    assign cfg_we[r] = csr_we_i & cfg_hit & (cfg_off == Word) &
                       ~cfg_q[r].lock & ~wr_no_rd;

    // A locked TOR region above also freezes this address, it is its base
    if (r + 1 < NumRegions) begin : g_upper
      assign tor_locked = cfg_q[r+1].lock & (cfg_q[r+1].mode == PMP_MODE_TOR);
    end else begin : g_top
      assign tor_locked = 1'b0;
    end

    assign addr_we[r] = csr_we_i & addr_hit & (addr_off == r) &
                        ~cfg_q[r].lock & ~tor_locked;

    // pmpaddr holds address bits 33:2
    assign addr_o[r] = {addr_q[r], 2'b00};
  end

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else begin
      for (int r = 0; r < NumRegions; r++) begin
        if (cfg_we[r]) begin
          cfg_q[r] <= cfg_wval[r];
        end
        if (addr_we[r]) begin
          addr_q[r] <= csr_wdata_i;
        end
      end
    end
  end

  assign cfg_o = cfg_q;

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------

  always_comb begin
    rd_word.raw = '0;
    for (int k = 0; k < NumWords; k++) begin
      if (cfg_off == k) begin
        for (int s = 0; s < 4; s++) begin
          rd_word.entry[s] = cfg_q[4*k+s];
        end
      end
    end
  end

  always_comb begin
    addr_rdata = '0;
    for (int r = 0; r < NumRegions; r++) begin
      if (addr_off == r) begin
        addr_rdata = addr_q[r];
      end
    end
  end

  // Unimplemented numbers fall through to zero
  assign csr_rdata_o = cfg_hit  ? rd_word.raw :
                       addr_hit ? addr_rdata  : 32'h0;

endmodule

/* source/pmp_pkg.sv */
/*
 * PMP types: address mode, access type, privilege level,
 * the region config byte and the pmpcfg CSR word
 */
package pmp_pkg;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  // Region address matching mode, field A of a config byte
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Kind of access presented on a channel
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_req_e;

  // Privilege of the requester, only U and M exist here
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // ------------------------------------------------------------
  // CSR layouts
  // ------------------------------------------------------------

  // One region config byte, L at bit 7 down to R at bit 0
  typedef struct packed {
    logic      lock;
    logic [1:0] reserved;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // A pmpcfg CSR seen as a raw word or as four region bytes,
  // entry[0] sits in bits 7:0
  typedef union packed {
    logic [31:0]         raw;
    pmp_cfg_t [3:0]      entry;
  } pmp_cfg_word_u;

endpackage

/* source/pmp_config.svh */
/*
 * Compile-time sizing for the PMP unit: region and channel counts,
 * NAPOT granularity and the CSR numbers of the pmpcfg/pmpaddr banks
 */
`ifndef PMP_CONFIG_SVH
`define PMP_CONFIG_SVH

// Implemented regions, kept a multiple of 4 so pmpcfg words are whole
`define PMP_NUM_REGIONS 4

// Access channels, 0 is instruction fetch and 1 is data
`define PMP_NUM_CHAN 2

// NAPOT granularity exponent G, one granule is 2^(G+2) bytes
`define PMP_GRANULARITY 0

// First CSR numbers of the two register banks
`define PMP_CSR_CFG_BASE 12'h3A0
`define PMP_CSR_ADDR_BASE 12'h3B0

// Derived sizes
`define PMP_NUM_CFG_WORDS (`PMP_NUM_REGIONS / 4)
`define PMP_CHAN_IDX_W (($clog2(`PMP_NUM_CHAN) > 0) ? $clog2(`PMP_NUM_CHAN) : 1)

`endif
